/* hw/mem_pkg.sv */
package mem_pkg;

    // ============================================================
    // Memory-side widths
    // ============================================================
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;

    // Access size of a memory uop
    typedef enum logic [1:0] {
        MSZ_B = 2'd0,
        MSZ_H = 2'd1,
        MSZ_W = 2'd2
    } mem_size_e;

    // Word-aligned store request, data already placed in its lanes
    typedef struct packed {
        addr_t addr;
        word_t data;
        strb_t strb;
    } dmem_store_t;

endpackage

/* hw/lsu_pkg.sv */
package lsu_pkg;

    localparam int ROB_W    = 6;
    localparam int PHYS_W   = 6;
    localparam int SQ_DEPTH = 4;
    localparam int SQ_IDX_W = 2;

    typedef logic [ROB_W-1:0]  rob_idx_t;
    typedef logic [PHYS_W-1:0] preg_t;

    // ============================================================
    // Core-side records
    // ============================================================
    typedef struct packed {
        rob_idx_t           rob_idx;
        mem_pkg::mem_size_e size;
    } sq_alloc_t;

    typedef struct packed {
        rob_idx_t       rob_idx;
        mem_pkg::addr_t base;
        mem_pkg::word_t imm;
        mem_pkg::word_t value;
    } store_exec_t;

    typedef struct packed {
        rob_idx_t           rob_idx;
        preg_t              preg;
        mem_pkg::addr_t     base;
        mem_pkg::word_t     imm;
        mem_pkg::mem_size_e size;
        logic               is_unsigned;
    } load_uop_t;

    // Data is kept lane-aligned, strb marks the written bytes
    typedef struct packed {
        rob_idx_t           rob_idx;
        mem_pkg::mem_size_e size;
        mem_pkg::addr_t     addr;
        mem_pkg::word_t     data;
        mem_pkg::strb_t     strb;
        logic               addr_rdy;
        logic               data_rdy;
        logic               committed;
    } sq_entry_t;

    typedef struct packed {
        rob_idx_t       rob_idx;
        preg_t          preg;
        mem_pkg::word_t data;
    } load_wb_t;

endpackage

/* hw/lsu_agu.sv */
`timescale 1ns/1ps

module lsu_agu (
    input  mem_pkg::addr_t     base,
    input  mem_pkg::word_t     imm,
    input  mem_pkg::mem_size_e size,
    output mem_pkg::addr_t     addr,
    output mem_pkg::strb_t     lanes
);

    logic [1:0] off;

    assign addr = base + imm;
    assign off  = addr[1:0];

    // Byte lanes touched inside the 32-bit word
    // Halves and words are assumed naturally aligned
    always_comb begin
        case (size)
            mem_pkg::MSZ_B: begin
                lanes = 4'b0001 << off;
            end
            mem_pkg::MSZ_H: begin
                lanes = 4'b0011 << {off[1], 1'b0};
            end
            mem_pkg::MSZ_W: begin
                lanes = 4'b1111;
            end
            default: begin
                lanes = 4'b0000;
            end
        endcase
    end

endmodule

/* hw/lsu_store_queue.sv */
`timescale 1ns/1ps

module lsu_store_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,

    input  logic                 alloc_valid,
    output logic                 alloc_ready,
    input  lsu_pkg::sq_alloc_t   alloc,

    input  logic                 st_exec_valid,
    input  lsu_pkg::store_exec_t st_exec,
    input  mem_pkg::addr_t       st_addr,
    input  mem_pkg::strb_t       st_lanes,

    input  logic                 commit_valid,
    input  lsu_pkg::rob_idx_t    commit_rob_idx,

    output lsu_pkg::sq_entry_t   entries [lsu_pkg::SQ_DEPTH],
    output logic [lsu_pkg::SQ_DEPTH-1:0] entry_valid,

    output logic                 dmem_st_valid,
    input  logic                 dmem_st_ready,
    output mem_pkg::dmem_store_t dmem_st
);

    logic [lsu_pkg::SQ_IDX_W-1:0] head;
    logic [lsu_pkg::SQ_IDX_W-1:0] tail;
    logic [lsu_pkg::SQ_IDX_W:0]   count;

    logic alloc_fire;
    logic head_send;
    logic st_fire;

    assign alloc_ready = (count != lsu_pkg::SQ_DEPTH);
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign st_fire     = dmem_st_valid && dmem_st_ready;

    // Head is eligible once committed and filled, and not already on the port
    assign head_send = entry_valid[head] && !dmem_st_valid
                       && entries[head].committed
                       && entries[head].addr_rdy
                       && entries[head].data_rdy;

    // ============================================================
    // Pointers, valid bits and store port handshake
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            entry_valid   <= '0;
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            dmem_st_valid <= 1'b0;
        end else begin
            if (alloc_fire) begin
                entry_valid[tail] <= 1'b1;
                tail              <= tail + 1'b1;
            end
            if (head_send) begin
                dmem_st_valid <= 1'b1;
            end else if (st_fire) begin
                dmem_st_valid     <= 1'b0;
                entry_valid[head] <= 1'b0;
                head              <= head + 1'b1;
            end
            case ({alloc_fire, st_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry contents, qualified by entry_valid
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            entries[tail].rob_idx   <= alloc.rob_idx;
            entries[tail].size      <= alloc.size;
            entries[tail].addr_rdy  <= 1'b0;
            entries[tail].data_rdy  <= 1'b0;
            entries[tail].committed <= 1'b0;
        end
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (st_exec_valid && entry_valid[i] && entries[i].rob_idx == st_exec.rob_idx) begin
                entries[i].addr     <= st_addr;
                entries[i].data     <= st_exec.value << {st_addr[1:0], 3'b000};
                entries[i].strb     <= st_lanes;
                entries[i].addr_rdy <= 1'b1;
                entries[i].data_rdy <= 1'b1;
            end
            if (commit_valid && entry_valid[i] && entries[i].rob_idx == commit_rob_idx) begin
                entries[i].committed <= 1'b1;
            end
        end
        if (head_send) begin
            dmem_st.addr <= {entries[head].addr[31:2], 2'b00};
            dmem_st.data <= entries[head].data;
            dmem_st.strb <= entries[head].strb;
        end
    end

endmodule

/* hw/lsu_fwd_search.sv */
`timescale 1ns/1ps

module lsu_fwd_search (
    input  lsu_pkg::sq_entry_t entries [lsu_pkg::SQ_DEPTH],
    input  logic [lsu_pkg::SQ_DEPTH-1:0] entry_valid,
    input  lsu_pkg::rob_idx_t  ld_rob_idx,
    input  mem_pkg::addr_t     ld_addr,
    input  mem_pkg::strb_t     ld_lanes,
    output logic               older_pending,
    output logic               fwd_hit,
    output logic               fwd_blocked,
    output mem_pkg::word_t     fwd_data
);

    logic [lsu_pkg::SQ_DEPTH-1:0] older;
    logic [lsu_pkg::SQ_DEPTH-1:0] overlap;
    logic                         found;
    lsu_pkg::rob_idx_t            best_rob;
    lsu_pkg::sq_entry_t           best;

    // Age is plain ROB order, indices never wrap between flushes
    always_comb begin
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            older[i]   = entry_valid[i] && (entries[i].rob_idx < ld_rob_idx);
            overlap[i] = older[i] && entries[i].addr_rdy
                         && (entries[i].addr[31:2] == ld_addr[31:2])
                         && |(entries[i].strb & ld_lanes);
        end
    end

    always_comb begin
        older_pending = 1'b0;
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (older[i] && !(entries[i].addr_rdy && entries[i].data_rdy)) begin
                older_pending = 1'b1;
            end
        end
    end

    // Youngest older overlapping store wins
    always_comb begin
        found    = 1'b0;
        best_rob = '0;
        best     = entries[0];
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (overlap[i] && (!found || entries[i].rob_idx > best_rob)) begin
                found    = 1'b1;
                best_rob = entries[i].rob_idx;
                best     = entries[i];
            end
        end
    end

    assign fwd_hit     = found && ((ld_lanes & ~best.strb) == 4'b0000);
    assign fwd_blocked = found && !fwd_hit;
    assign fwd_data    = best.data;

endmodule

/* hw/lsu_load_pipe.sv */
`timescale 1ns/1ps

module lsu_load_pipe (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               ld_valid,
    output logic               ld_ready,
    input  lsu_pkg::load_uop_t ld_req,
    input  mem_pkg::addr_t     ld_addr,
    input  logic               older_pending,
    input  logic               fwd_hit,
    input  logic               fwd_blocked,
    input  mem_pkg::word_t     fwd_data,
    output logic               dmem_ld_valid,
    input  logic               dmem_ld_ready,
    output mem_pkg::addr_t     dmem_ld_addr,
    input  logic               dmem_ld_resp_valid,
    input  mem_pkg::word_t     dmem_ld_resp_data,
    output logic               wb_valid,
    input  logic               wb_ready,
    output lsu_pkg::load_wb_t  wb
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT_RESP
    } state_e;

    state_e             state;
    lsu_pkg::load_uop_t hold_req;
    mem_pkg::addr_t     hold_addr;
    logic               resp_stale;
    logic               accept;
    logic               fwd_enq;
    logic               mem_enq;

    function automatic mem_pkg::word_t extract(
        input mem_pkg::word_t     w,
        input logic [1:0]         off,
        input mem_pkg::mem_size_e size,
        input logic               is_unsigned
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{off, 3'b000} +: 8];
        h = w[{off[1], 4'b0000} +: 16];
        case (size)
            mem_pkg::MSZ_B: return is_unsigned ? {24'b0, b} : {{24{b[7]}}, b};
            mem_pkg::MSZ_H: return is_unsigned ? {16'b0, h} : {{16{h[15]}}, h};
            default:        return w;
        endcase
    endfunction

    // One load at a time, and none while a flushed response is still due
    assign ld_ready = ld_valid && (state == S_IDLE) && !resp_stale && !flush
                      && !older_pending && !fwd_blocked && (!wb_valid || wb_ready);
    assign accept   = ld_ready;
    assign fwd_enq  = accept && fwd_hit;
    assign mem_enq  = (state == S_WAIT_RESP) && dmem_ld_resp_valid;

    assign dmem_ld_valid = (state == S_ISSUE);
    assign dmem_ld_addr  = {hold_addr[31:2], 2'b00};

    // ============================================================
    // FSM and writeback valid
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            resp_stale <= 1'b0;
            wb_valid   <= 1'b0;
        end else if (flush) begin
            state      <= S_IDLE;
            wb_valid   <= 1'b0;
            resp_stale <= (state == S_WAIT_RESP && !dmem_ld_resp_valid)
                          || (dmem_ld_valid && dmem_ld_ready)
                          || (resp_stale && !dmem_ld_resp_valid);
        end else begin
            if (resp_stale && dmem_ld_resp_valid) begin
                resp_stale <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (accept && !fwd_hit) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (dmem_ld_ready) begin
                        state <= S_WAIT_RESP;
                    end
                end
                S_WAIT_RESP: begin
                    if (dmem_ld_resp_valid) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
            if (fwd_enq || mem_enq) begin
                wb_valid <= 1'b1;
            end else if (wb_ready) begin
                wb_valid <= 1'b0;
            end
        end
    end

    // Holding register and writeback payload
    always_ff @(posedge clk) begin
        if (accept && !fwd_hit) begin
            hold_req  <= ld_req;
            hold_addr <= ld_addr;
        end
        if (fwd_enq) begin
            wb.rob_idx <= ld_req.rob_idx;
            wb.preg    <= ld_req.preg;
            wb.data    <= extract(fwd_data, ld_addr[1:0], ld_req.size, ld_req.is_unsigned);
        end else if (mem_enq) begin
            wb.rob_idx <= hold_req.rob_idx;
            wb.preg    <= hold_req.preg;
            wb.data    <= extract(dmem_ld_resp_data, hold_addr[1:0], hold_req.size,
                                  hold_req.is_unsigned);
        end
    end

endmodule

/* hw/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 alloc_valid,
    output logic                 alloc_ready,
    input  lsu_pkg::sq_alloc_t   alloc,
    input  logic                 st_exec_valid,
    input  lsu_pkg::store_exec_t st_exec,
    input  logic                 commit_valid,
    input  lsu_pkg::rob_idx_t    commit_rob_idx,
    input  logic                 ld_valid,
    output logic                 ld_ready,
    input  lsu_pkg::load_uop_t   ld_req,
    output logic                 dmem_st_valid,
    input  logic                 dmem_st_ready,
    output mem_pkg::dmem_store_t dmem_st,
    output logic                 dmem_ld_valid,
    input  logic                 dmem_ld_ready,
    output mem_pkg::addr_t       dmem_ld_addr,
    input  logic                 dmem_ld_resp_valid,
    input  mem_pkg::word_t       dmem_ld_resp_data,
    output logic                 wb_valid,
    input  logic                 wb_ready,
    output lsu_pkg::load_wb_t    wb
);

    lsu_pkg::sq_entry_t           sq_entries [lsu_pkg::SQ_DEPTH];
    logic [lsu_pkg::SQ_DEPTH-1:0] sq_valid;
    mem_pkg::mem_size_e           st_size;
    mem_pkg::addr_t               st_addr;
    mem_pkg::strb_t               st_lanes;
    mem_pkg::addr_t               ld_addr;
    mem_pkg::strb_t               ld_lanes;
    logic                         older_pending;
    logic                         fwd_hit;
    logic                         fwd_blocked;
    mem_pkg::word_t               fwd_data;

    // Store size was recorded at allocation, look it up by ROB index
    always_comb begin
        st_size = mem_pkg::MSZ_W;
        for (int i = 0; i < lsu_pkg::SQ_DEPTH; i++) begin
            if (sq_valid[i] && sq_entries[i].rob_idx == st_exec.rob_idx) begin
                st_size = sq_entries[i].size;
            end
        end
    end

    lsu_agu u_st_agu (
        .base  (st_exec.base),
        .imm   (st_exec.imm),
        .size  (st_size),
        .addr  (st_addr),
        .lanes (st_lanes)
    );

    lsu_agu u_ld_agu (
        .base  (ld_req.base),
        .imm   (ld_req.imm),
        .size  (ld_req.size),
        .addr  (ld_addr),
        .lanes (ld_lanes)
    );

    lsu_store_queue u_sq (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .alloc_valid    (alloc_valid),
        .alloc_ready    (alloc_ready),
        .alloc          (alloc),
        .st_exec_valid  (st_exec_valid),
        .st_exec        (st_exec),
        .st_addr        (st_addr),
        .st_lanes       (st_lanes),
        .commit_valid   (commit_valid),
        .commit_rob_idx (commit_rob_idx),
        .entries        (sq_entries),
        .entry_valid    (sq_valid),
        .dmem_st_valid  (dmem_st_valid),
        .dmem_st_ready  (dmem_st_ready),
        .dmem_st        (dmem_st)
    );

    lsu_fwd_search u_fwd (
        .entries       (sq_entries),
        .entry_valid   (sq_valid),
        .ld_rob_idx    (ld_req.rob_idx),
        .ld_addr       (ld_addr),
        .ld_lanes      (ld_lanes),
        .older_pending (older_pending),
        .fwd_hit       (fwd_hit),
        .fwd_blocked   (fwd_blocked),
        .fwd_data      (fwd_data)
    );

    lsu_load_pipe u_ld_pipe (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush              (flush),
        .ld_valid           (ld_valid),
        .ld_ready           (ld_ready),
        .ld_req             (ld_req),
        .ld_addr            (ld_addr),
        .older_pending      (older_pending),
        .fwd_hit            (fwd_hit),
        .fwd_blocked        (fwd_blocked),
        .fwd_data           (fwd_data),
        .dmem_ld_valid      (dmem_ld_valid),
        .dmem_ld_ready      (dmem_ld_ready),
        .dmem_ld_addr       (dmem_ld_addr),
        .dmem_ld_resp_valid (dmem_ld_resp_valid),
        .dmem_ld_resp_data  (dmem_ld_resp_data),
        .wb_valid           (wb_valid),
        .wb_ready           (wb_ready),
        .wb                 (wb)
    );

endmodule

/* tests/lsu_sva.sv */
`timescale 1ns/1ps

module lsu_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 flush,
    input logic                 alloc_ready,
    input logic                 ld_ready,
    input logic                 dmem_st_valid,
    input logic                 dmem_st_ready,
    input mem_pkg::dmem_store_t dmem_st,
    input logic                 dmem_ld_valid,
    input logic                 dmem_ld_ready,
    input logic                 dmem_ld_resp_valid,
    input logic                 wb_valid,
    input logic                 wb_ready,
    input lsu_pkg::load_wb_t    wb
);

    logic ld_outstanding;

    // Set on the request handshake, cleared by the response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_outstanding <= 1'b0;
        end else if (dmem_ld_valid && dmem_ld_ready) begin
            ld_outstanding <= 1'b1;
        end else if (dmem_ld_resp_valid) begin
            ld_outstanding <= 1'b0;
        end
    end

    a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n || flush)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb))
        else $error("wb changed while stalled");

    a_st_stable: assert property (@(posedge clk) disable iff (!rst_n || flush)
        dmem_st_valid && !dmem_st_ready |=> dmem_st_valid && $stable(dmem_st))
        else $error("dmem_st changed while stalled");

    a_one_load: assert property (@(posedge clk) disable iff (!rst_n)
        ld_outstanding |-> !dmem_ld_valid)
        else $error("dmem_ld_valid with a response outstanding");

    a_reset_out: assert property (@(posedge clk)
        $rose(rst_n) |-> alloc_ready && !ld_ready && !dmem_st_valid
                         && !dmem_ld_valid && !wb_valid)
        else $error("outputs wrong after reset");

endmodule

bind lsu_top lsu_sva u_sva (.*);

/* tests/tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 alloc_valid;
    logic                 alloc_ready;
    lsu_pkg::sq_alloc_t   alloc;
    logic                 st_exec_valid;
    lsu_pkg::store_exec_t st_exec;
    logic                 commit_valid;
    lsu_pkg::rob_idx_t    commit_rob_idx;
    logic                 ld_valid;
    logic                 ld_ready;
    lsu_pkg::load_uop_t   ld_req;
    logic                 dmem_st_valid;
    logic                 dmem_st_ready;
    mem_pkg::dmem_store_t dmem_st;
    logic                 dmem_ld_valid;
    logic                 dmem_ld_ready;
    mem_pkg::addr_t       dmem_ld_addr;
    logic                 dmem_ld_resp_valid;
    mem_pkg::word_t       dmem_ld_resp_data;
    logic                 wb_valid;
    logic                 wb_ready;
    lsu_pkg::load_wb_t    wb;

    integer seed = 68;
    integer cycles = 0;
    integer cycle_limit = 0;
    integer error_count = 0;
    integer committed_cnt = 0;
    integer drained_cnt = 0;

    string              lines[$];
    lsu_pkg::load_uop_t ld_q[$];
    lsu_pkg::load_wb_t  exp_q[$];
    logic [7:0]         mem [logic [31:0]];

    lsu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // Checks
    // ============================================================
    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s actual 0x%h expected 0x%h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            abort_run("Timeout: the test did not finish in time");
        end
    end

    // ============================================================
    // Memory model
    // ============================================================
    // Untouched bytes hash the full address
    function automatic logic [7:0] read_byte(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        return {read_byte(a + 3), read_byte(a + 2), read_byte(a + 1), read_byte(a)};
    endfunction

    initial begin : mem_model
        logic [31:0] resp_addr;
        integer      resp_wait;
        resp_wait = 0;
        resp_addr = '0;
        forever begin
            @(posedge clk);
            if (dmem_st_valid && dmem_st_ready) begin
                if (drained_cnt >= committed_cnt) begin
                    abort_run("Store request seen with no committed store left");
                end
                for (int i = 0; i < 4; i++) begin
                    if (dmem_st.strb[i]) begin
                        mem[dmem_st.addr + i] = dmem_st.data[8*i +: 8];
                    end
                end
                drained_cnt++;
            end
            if (dmem_ld_valid && dmem_ld_ready) begin
                resp_addr = dmem_ld_addr;
                resp_wait = 1 + ($unsigned($random(seed)) % 3);
            end
            #1;
            dmem_ld_resp_valid = 1'b0;
            if (resp_wait > 0) begin
                resp_wait--;
                if (resp_wait == 0) begin
                    dmem_ld_resp_valid = 1'b1;
                    dmem_ld_resp_data  = read_word(resp_addr);
                end
            end
            dmem_st_ready = 1'($random(seed));
            dmem_ld_ready = 1'($random(seed));
        end
    end

    // Load requests go out one at a time
    initial begin : load_driver
        logic acc;
        logic queued;
        forever begin
            @(posedge clk);
            acc    = ld_valid && ld_ready;
            queued = ld_q.size() > 0;
            #1;
            if (acc) begin
                ld_valid = 1'b0;
            end
            if (!ld_valid && queued) begin
                ld_req   = ld_q.pop_front();
                ld_valid = 1'b1;
            end
        end
    end

    // Writeback compare and stall rule
    always @(posedge clk) begin
        lsu_pkg::load_wb_t e;
        if (rst_n && wb_valid && !wb_ready && ld_ready) begin
            abort_run("A load was accepted while the writeback was stalled");
        end
        if (rst_n && wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("Writeback seen with no load pending");
            end
            e = exp_q.pop_front();
            check("wb.rob_idx", 32'(wb.rob_idx), 32'(e.rob_idx));
            check("wb.preg", 32'(wb.preg), 32'(e.preg));
            check("wb.data", wb.data, e.data);
        end
    end

    // ============================================================
    // Case sequencer
    // ============================================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
        alloc_valid   = 1'b0;
        st_exec_valid = 1'b0;
        commit_valid  = 1'b0;
        flush         = 1'b0;
    endtask

    task automatic run_line(input string line);
        string              op;
        logic [31:0]        a0, a1, a2, a3, a4, a5, a6;
        lsu_pkg::load_uop_t u;
        lsu_pkg::load_wb_t  e;
        void'($sscanf(line, "%s %h %h %h %h %h %h %h", op, a0, a1, a2, a3, a4, a5, a6));
        case (op)
            "alloc": begin
                while (!alloc_ready) next_cycle();
                alloc_valid   = 1'b1;
                alloc.rob_idx = a0[5:0];
                alloc.size    = mem_pkg::mem_size_e'(a1[1:0]);
                next_cycle();
            end
            "exec": begin
                st_exec_valid   = 1'b1;
                st_exec.rob_idx = a0[5:0];
                st_exec.base    = a1;
                st_exec.imm     = a2;
                st_exec.value   = a3;
                next_cycle();
            end
            "commit": begin
                commit_valid   = 1'b1;
                commit_rob_idx = a0[5:0];
                committed_cnt++;
                next_cycle();
            end
            "flush": begin
                flush = 1'b1;
                next_cycle();
                committed_cnt = drained_cnt;
            end
            "load": begin
                u.rob_idx     = a0[5:0];
                u.preg        = a1[5:0];
                u.base        = a2;
                u.imm         = a3;
                u.size        = mem_pkg::mem_size_e'(a4[1:0]);
                u.is_unsigned = a5[0];
                e.rob_idx     = a0[5:0];
                e.preg        = a1[5:0];
                e.data        = a6;
                exp_q.push_back(e);
                ld_q.push_back(u);
                next_cycle();
            end
            "idle": repeat (a0) next_cycle();
            "wbready": begin
                wb_ready = a0[0];
                next_cycle();
            end
            "wait": begin
                while (ld_q.size() != 0 || ld_valid || exp_q.size() != 0) next_cycle();
            end
            "drain": begin
                while (drained_cnt < committed_cnt) next_cycle();
            end
            "allocrdy": check("alloc_ready", 32'(alloc_ready), a0);
            default: abort_run({"Unknown operation in case file: ", op});
        endcase
    endtask

    initial begin : main
        integer fd;
        string  line;
        rst_n              = 1'b0;
        flush              = 1'b0;
        alloc_valid        = 1'b0;
        alloc              = '0;
        st_exec_valid      = 1'b0;
        st_exec            = '0;
        commit_valid       = 1'b0;
        commit_rob_idx     = '0;
        ld_valid           = 1'b0;
        ld_req             = '0;
        dmem_st_ready      = 1'b0;
        dmem_ld_ready      = 1'b0;
        dmem_ld_resp_valid = 1'b0;
        dmem_ld_resp_data  = '0;
        wb_ready           = 1'b1;

        fd = $fopen("tests/lsu_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open tests/lsu_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 40 * lines.size() + 200;

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        run_line("wait");
        run_line("drain");

        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tests/lsu_cases.txt */
# op fields (hex): alloc rob size | exec rob base imm value | commit rob | flush
# load rob preg base imm size unsigned expected | idle n | wbready v | wait | drain | allocrdy v
alloc 1 2
exec 1 00000100 00000000 8899aabb
commit 1
alloc 2 0
exec 2 00000100 00000005 000000f0
commit 2
alloc 3 1
exec 3 00000100 00000006 00008123
commit 3
alloc 4 0
exec 4 00000104 00000000 0000007f
commit 4
drain
load 5 1 00000100 00000002 1 0 ffff8899
load 6 2 00000104 00000000 2 0 8123f07f
load 7 3 00000100 00000005 0 0 fffffff0
load 8 4 00000100 00000005 0 1 000000f0
load 9 5 00000100 00000001 0 1 000000aa
wait
alloc a 2
exec a 00000100 00000000 11223344
alloc b 1
exec b 00000100 00000002 0000cafe
load c 6 00000100 00000002 1 1 0000cafe
load d 7 00000100 00000000 0 0 00000044
wait
flush
load 14 8 00000100 00000000 2 0 8899aabb
wait
alloc 15 2
load 16 9 00000200 00000000 2 1 5a5aa5a5
idle 5
exec 15 00000200 00000000 5a5aa5a5
wait
commit 15
drain
wbready 0
load 17 a 00000200 00000000 0 1 000000a5
load 18 b 00000200 00000003 0 0 0000005a
idle 8
wbready 1
wait
alloc 19 2
alloc 1a 2
alloc 1b 2
alloc 1c 2
allocrdy 0
exec 19 00000300 00000000 01020304
commit 19
drain
allocrdy 1
flush
load 1 c 00000300 00000000 2 0 01020304
wait

/* tb.f */
hw/mem_pkg.sv
hw/lsu_pkg.sv
hw/lsu_agu.sv
hw/lsu_store_queue.sv
hw/lsu_fwd_search.sv
hw/lsu_load_pipe.sv
hw/lsu_top.sv
tests/lsu_sva.sv
tests/tb_lsu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
